//--- rtl/mipsPkg.sv
package mipsPkg;

	// data path widths
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [1:0] fwdSel_t;

	// request/ready handshake with the instruction memory
	typedef enum logic [1:0] {fetchIdle, fetchWait, fetchDrop} fetchState_t;

	localparam word_t instrBytes = 32'd4;
	localparam word_t resetPc = 32'h0000_0000;

	// alu operations
	localparam aluOp_t aluAdd = 3'd0;
	localparam aluOp_t aluSub = 3'd1;
	localparam aluOp_t aluAnd = 3'd2;
	localparam aluOp_t aluOr = 3'd3;
	localparam aluOp_t aluSlt = 3'd4;

	// where an execute operand comes from
	localparam fwdSel_t fwdNone = 2'd0;
	localparam fwdSel_t fwdWriteback = 2'd1;
	localparam fwdSel_t fwdMemory = 2'd2;

	// primary opcodes
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opLui = 6'b001111;

	// funct codes of r-type
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnSlt = 6'b101010;

endpackage

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
(
	input logic rst,
	input logic reset,
	output logic fetchReq,
	output mipsPkg::word_t fetchAddr,
	input logic fetchReady,
	input mipsPkg::word_t fetchData,
	input logic stallD,
	input logic redirect,
	input mipsPkg::word_t redirectTarget,
	output mipsPkg::word_t instrD,
	output mipsPkg::word_t pcPlus4D,
	output logic validD
);
	import mipsPkg::*;

	fetchState_t state;
	word_t pc;
	word_t reqAddr;
	logic holdD;
	logic startReq;
	logic capture;

	// decode keeps its instruction while a branch waits on execute
	assign holdD = validD && stallD;
	assign startReq = (state == fetchIdle) && !holdD;

	// a response overtaken by a redirect is thrown away
	assign capture = (state == fetchWait) && fetchReady && !redirect;

	assign fetchReq = (state != fetchIdle);
	assign fetchAddr = reqAddr;

	always_ff @(posedge rst)
	begin
		if (reset)
			state <= fetchIdle;
		else
		begin
			case (state)
				fetchIdle:
				begin
					if (startReq)
						state <= fetchWait;
				end
				fetchWait:
				begin
					// idle after every response, so the request drops for a cycle
					if (fetchReady)
						state <= fetchIdle;
					else if (redirect)
						state <= fetchDrop;
				end
				fetchDrop:
				begin
					if (fetchReady)
						state <= fetchIdle;
				end
				default: state <= fetchIdle;
			endcase
		end
	end

	always_ff @(posedge rst)
	begin
		if (reset)
		begin
			pc <= resetPc;
			reqAddr <= resetPc;
			validD <= 1'b0;
		end
		else
		begin
			if (redirect)
				pc <= redirectTarget;
			else if (capture)
				pc <= pc + instrBytes;

			// a new request already follows a redirect from this cycle
			if (startReq)
				reqAddr <= redirect ? redirectTarget : pc;

			if (redirect)
				validD <= 1'b0;
			else if (capture)
				validD <= 1'b1;
			else if (!stallD)
				validD <= 1'b0;
		end
	end

	// fetch/decode register
	always_ff @(posedge rst)
	begin
		if (capture)
		begin
			instrD <= fetchData;
			pcPlus4D <= pc + instrBytes;
		end
	end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile
(
	input logic rst,
	input mipsPkg::regAddr_t readAddrA,
	input mipsPkg::regAddr_t readAddrB,
	output mipsPkg::word_t readDataA,
	output mipsPkg::word_t readDataB,
	input logic writeEnable,
	input mipsPkg::regAddr_t writeAddr,
	input mipsPkg::word_t writeData
);
	import mipsPkg::*;

	word_t regs [32];

	// $0 never gets written
	always_ff @(posedge rst)
	begin
		if (writeEnable && (writeAddr != '0))
			regs[writeAddr] <= writeData;
	end

	// write-first, so decode sees the value committed this cycle
	always_comb
	begin
		if (readAddrA == '0)
			readDataA = '0;
		else if (writeEnable && (writeAddr == readAddrA))
			readDataA = writeData;
		else
			readDataA = regs[readAddrA];

		if (readAddrB == '0)
			readDataB = '0;
		else if (writeEnable && (writeAddr == readAddrB))
			readDataB = writeData;
		else
			readDataB = regs[readAddrB];
	end

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
(
	input logic rst,
	input logic reset,
	input mipsPkg::word_t instrD,
	input mipsPkg::word_t pcPlus4D,
	input logic validD,
	input logic stallD,
	input logic forwardAD,
	input logic forwardBD,
	input mipsPkg::word_t aluOutM,
	input logic wbValid,
	input mipsPkg::regAddr_t wbReg,
	input mipsPkg::word_t wbData,
	output logic redirect,
	output mipsPkg::word_t redirectTarget,
	output logic validE,
	output logic regWriteE,
	output mipsPkg::regAddr_t writeRegE,
	output mipsPkg::regAddr_t rsE,
	output mipsPkg::regAddr_t rtE,
	output mipsPkg::word_t rd1E,
	output mipsPkg::word_t rd2E,
	output mipsPkg::word_t immE,
	output mipsPkg::aluOp_t aluOpE,
	output logic aluSrcImmE,
	output mipsPkg::regAddr_t rsD,
	output mipsPkg::regAddr_t rtD,
	output logic branchD
);
	import mipsPkg::*;

	logic [5:0] op;
	logic [5:0] funct;
	regAddr_t rdD;
	regAddr_t writeRegD;
	word_t rd1D;
	word_t rd2D;
	word_t cmpA;
	word_t cmpB;
	word_t signImm;
	word_t immD;
	word_t branchTarget;
	word_t jumpTarget;
	aluOp_t aluOpD;
	logic regWriteD;
	logic aluSrcImmD;
	logic destRd;
	logic isBeq;
	logic isBne;
	logic isJump;
	logic takeBranch;

	assign op = instrD[31:26];
	assign funct = instrD[5:0];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign signImm = {{16{instrD[15]}}, instrD[15:0]};

	// controller, anything not listed decodes as a no-op
	always_comb
	begin
		regWriteD = 1'b0;
		aluOpD = aluAdd;
		aluSrcImmD = 1'b0;
		destRd = 1'b0;
		immD = signImm;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		case (op)
			opRType:
			begin
				destRd = 1'b1;
				regWriteD = 1'b1;
				case (funct)
					fnAdd: aluOpD = aluAdd;
					fnSub: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr: aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					default: regWriteD = 1'b0;
				endcase
			end
			opAddi:
			begin
				regWriteD = 1'b1;
				aluSrcImmD = 1'b1;
			end
			opAndi, opOri:
			begin
				regWriteD = 1'b1;
				aluSrcImmD = 1'b1;
				aluOpD = (op == opAndi) ? aluAnd : aluOr;
				immD = {16'h0000, instrD[15:0]};
			end
			// rs is $0 here, so or just passes the padded immediate
			opLui:
			begin
				regWriteD = 1'b1;
				aluSrcImmD = 1'b1;
				aluOpD = aluOr;
				immD = {instrD[15:0], 16'h0000};
			end
			opBeq: isBeq = 1'b1;
			opBne: isBne = 1'b1;
			opJ: isJump = 1'b1;
			default: regWriteD = 1'b0;
		endcase
	end

	regFile registers
	(
		.rst(rst),
		.readAddrA(rsD),
		.readAddrB(rtD),
		.readDataA(rd1D),
		.readDataB(rd2D),
		.writeEnable(wbValid),
		.writeAddr(wbReg),
		.writeData(wbData)
	);

	// branch compare sees the memory-stage result early
	assign cmpA = forwardAD ? aluOutM : rd1D;
	assign cmpB = forwardBD ? aluOutM : rd2D;
	assign takeBranch = (isBeq && (cmpA == cmpB)) || (isBne && (cmpA != cmpB));

	assign branchTarget = pcPlus4D + {signImm[29:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	assign branchD = validD && (isBeq || isBne);
	assign redirect = validD && !stallD && (takeBranch || isJump);
	assign redirectTarget = isJump ? jumpTarget : branchTarget;
	assign writeRegD = destRd ? rdD : rtD;

	always_ff @(posedge rst)
	begin
		if (reset)
		begin
			validE <= 1'b0;
			regWriteE <= 1'b0;
		end
		else
		begin
			// bubble into execute while the branch waits
			validE <= validD && !stallD;
			regWriteE <= validD && !stallD && regWriteD;
		end
	end

	always_ff @(posedge rst)
	begin
		writeRegE <= writeRegD;
		rsE <= rsD;
		rtE <= rtD;
		rd1E <= rd1D;
		rd2E <= rd2D;
		immE <= immD;
		aluOpE <= aluOpD;
		aluSrcImmE <= aluSrcImmD;
	end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
(
	input mipsPkg::regAddr_t rsD,
	input mipsPkg::regAddr_t rtD,
	input logic branchD,
	input mipsPkg::regAddr_t rsE,
	input mipsPkg::regAddr_t rtE,
	input mipsPkg::regAddr_t writeRegE,
	input logic regWriteE,
	input mipsPkg::regAddr_t writeRegM,
	input logic regWriteM,
	input mipsPkg::regAddr_t writeRegW,
	input logic regWriteW,
	output mipsPkg::fwdSel_t forwardAE,
	output mipsPkg::fwdSel_t forwardBE,
	output logic forwardAD,
	output logic forwardBD,
	output logic stallD
);
	import mipsPkg::*;

	// a later stage holds a result for this source register
	function automatic logic hits(input regAddr_t src, input regAddr_t dest, input logic write);
		return write && (dest != '0) && (dest == src);
	endfunction

	// memory stage is younger, so it wins over writeback
	function automatic fwdSel_t pickSource(input regAddr_t src, input regAddr_t destM,
		input logic writeM, input regAddr_t destW, input logic writeW);
		if (hits(src, destM, writeM))
			return fwdMemory;
		else if (hits(src, destW, writeW))
			return fwdWriteback;
		else
			return fwdNone;
	endfunction

	always_comb
	begin
		forwardAE = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
		forwardBE = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

		// writeback reaches decode through the register file bypass
		forwardAD = hits(rsD, writeRegM, regWriteM);
		forwardBD = hits(rtD, writeRegM, regWriteM);

		// branch operand still in the alu, wait one cycle for memory forwarding
		stallD = branchD && (hits(rsD, writeRegE, regWriteE) || hits(rtD, writeRegE, regWriteE));
	end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
	input logic rst,
	input logic reset,
	input logic validE,
	input logic regWriteE,
	input mipsPkg::regAddr_t writeRegE,
	input mipsPkg::word_t rd1E,
	input mipsPkg::word_t rd2E,
	input mipsPkg::word_t immE,
	input mipsPkg::aluOp_t aluOpE,
	input logic aluSrcImmE,
	input mipsPkg::fwdSel_t forwardAE,
	input mipsPkg::fwdSel_t forwardBE,
	output mipsPkg::word_t aluOutM,
	output mipsPkg::regAddr_t writeRegM,
	output logic regWriteM,
	output logic wbValid,
	output mipsPkg::regAddr_t wbReg,
	output mipsPkg::word_t wbData
);
	import mipsPkg::*;

	word_t srcA;
	word_t rtData;
	word_t srcB;
	word_t aluOutE;

	function automatic word_t forwardMux(input fwdSel_t sel, input word_t regValue,
		input word_t memValue, input word_t wbValue);
		case (sel)
			fwdMemory: return memValue;
			fwdWriteback: return wbValue;
			default: return regValue;
		endcase
	endfunction

	assign srcA = forwardMux(forwardAE, rd1E, aluOutM, wbData);
	assign rtData = forwardMux(forwardBE, rd2E, aluOutM, wbData);
	assign srcB = aluSrcImmE ? immE : rtData;

	always_comb
	begin
		case (aluOpE)
			aluAdd: aluOutE = srcA + srcB;
			aluSub: aluOutE = srcA - srcB;
			aluAnd: aluOutE = srcA & srcB;
			aluOr: aluOutE = srcA | srcB;
			// signed compare for slt
			aluSlt: aluOutE = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
			default: aluOutE = '0;
		endcase
	end

	always_ff @(posedge rst)
	begin
		if (reset)
		begin
			regWriteM <= 1'b0;
			wbValid <= 1'b0;
		end
		else
		begin
			// only real register writers move on as valid
			regWriteM <= validE && regWriteE;
			wbValid <= regWriteM;
		end
	end

	// execute/memory and memory/writeback data
	always_ff @(posedge rst)
	begin
		aluOutM <= aluOutE;
		writeRegM <= writeRegE;
		wbData <= aluOutM;
		wbReg <= writeRegM;
	end

endmodule

//--- rtl/mipsPipe.sv
`timescale 1ns/1ps

module mipsPipe
(
	input logic rst,
	input logic reset,
	output logic fetchReq,
	output mipsPkg::word_t fetchAddr,
	input logic fetchReady,
	input mipsPkg::word_t fetchData,
	output logic wbValid,
	output mipsPkg::regAddr_t wbReg,
	output mipsPkg::word_t wbData
);
	import mipsPkg::*;

	// fetch to decode
	word_t instrD;
	word_t pcPlus4D;
	logic validD;
	logic redirect;
	word_t redirectTarget;

	// decode to execute
	logic validE;
	logic regWriteE;
	regAddr_t writeRegE;
	regAddr_t rsE;
	regAddr_t rtE;
	word_t rd1E;
	word_t rd2E;
	word_t immE;
	aluOp_t aluOpE;
	logic aluSrcImmE;

	// hazard detection
	regAddr_t rsD;
	regAddr_t rtD;
	logic branchD;
	logic stallD;
	logic forwardAD;
	logic forwardBD;
	fwdSel_t forwardAE;
	fwdSel_t forwardBE;
	word_t aluOutM;
	regAddr_t writeRegM;
	logic regWriteM;

	fetchUnit fetch
	(
		.rst(rst),
		.reset(reset),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.fetchReady(fetchReady),
		.fetchData(fetchData),
		.stallD(stallD),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.validD(validD)
	);

	decodeStage decode
	(
		.rst(rst),
		.reset(reset),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.validD(validD),
		.stallD(stallD),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.aluOutM(aluOutM),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.validE(validE),
		.regWriteE(regWriteE),
		.writeRegE(writeRegE),
		.rsE(rsE),
		.rtE(rtE),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.immE(immE),
		.aluOpE(aluOpE),
		.aluSrcImmE(aluSrcImmE),
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD)
	);

	hazardUnit hazard
	(
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.regWriteE(regWriteE),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.writeRegW(wbReg),
		.regWriteW(wbValid),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.stallD(stallD)
	);

	executeStage execute
	(
		.rst(rst),
		.reset(reset),
		.validE(validE),
		.regWriteE(regWriteE),
		.writeRegE(writeRegE),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.immE(immE),
		.aluOpE(aluOpE),
		.aluSrcImmE(aluSrcImmE),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.aluOutM(aluOutM),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

//--- tests/mipsPipe_properties.sv
`timescale 1ns/1ps

module mipsPipe_properties
(
	input logic rst,
	input logic reset,
	input logic fetchReq,
	input mipsPkg::word_t fetchAddr,
	input logic fetchReady,
	input logic wbValid
);
	import mipsPkg::*;

	// failed assertions so far
	int failCount = 0;

	// address held until the memory answers
	addrHeld: assert property (@(posedge rst) disable iff (reset)
		(fetchReq && !fetchReady) |=> $stable(fetchAddr))
	else
	begin
		failCount++;
		$error("fetch address changed while a request was outstanding");
	end

	// request gap after every response
	reqDrops: assert property (@(posedge rst) disable iff (reset)
		fetchReady |=> !fetchReq)
	else
	begin
		failCount++;
		$error("fetch request stayed high after a response");
	end

	quietFetch: assert property (@(posedge rst)
		(reset && $past(reset)) |-> !fetchReq)
	else
	begin
		failCount++;
		$error("fetch request raised during reset");
	end

	quietCommit: assert property (@(posedge rst)
		(reset && $past(reset)) |-> !wbValid)
	else
	begin
		failCount++;
		$error("commit port active during reset");
	end

endmodule

bind mipsPipe mipsPipe_properties props
(
	.rst(rst),
	.reset(reset),
	.fetchReq(fetchReq),
	.fetchAddr(fetchAddr),
	.fetchReady(fetchReady),
	.wbValid(wbValid)
);

//--- tests/mipsPipe_tb.sv
`timescale 1ns/1ps

module mipsPipe_tb;
	import mipsPkg::*;

	logic rst;
	logic reset;
	logic fetchReq;
	word_t fetchAddr;
	logic fetchReady;
	word_t fetchData;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;

	// program image and expected commit stream
	word_t prog[$];
	regAddr_t expReg[$];
	word_t expData[$];

	int cycleCount = 0;
	int cycleLimit = 200;
	int totalLen = 0;
	int errorCount = 0;

	mipsPipe DUT
	(
		.rst(rst),
		.reset(reset),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.fetchReady(fetchReady),
		.fetchData(fetchData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	always #20 rst = ~rst;

	task automatic abortRun(input string reason);
		errorCount++;
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	always @(posedge rst)
	begin
		cycleCount++;
		if (DUT.props.failCount != 0)
			abortRun("A protocol assertion on the fetch or commit port failed");
		else if (cycleCount > cycleLimit)
			abortRun($sformatf("Timeout: the pipeline stopped committing after %0d cycles",
				cycleCount));
	end

	task automatic checkWord(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what,
				actual, expected));
	endtask

	task automatic checkReg(input regAddr_t actual, input regAddr_t expected,
		input string what);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0d ns: %s is $%0d, expected $%0d", $time, what,
				actual, expected));
	endtask

	task automatic checkFlag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what,
				actual, expected));
	endtask

	function automatic word_t readWord(input word_t addr);
		if (addr[31:2] < prog.size())
			return prog[addr[31:2]];
		return '0;
	endfunction

	// instruction memory answering 1 to 4 cycles after the request
	initial
	begin
		logic pending;
		int waitLeft;
		pending = 1'b0;
		waitLeft = 0;
		void'($urandom(32'h0a4971e8));
		forever
		begin
			@(posedge rst);
			#1;
			if (fetchReady || !fetchReq)
			begin
				fetchReady = 1'b0;
				pending = 1'b0;
			end
			else if (!pending)
			begin
				pending = 1'b1;
				waitLeft = 1 + ($urandom % 4);
			end
			else
			begin
				waitLeft--;
				if (waitLeft == 0)
				begin
					fetchReady = 1'b1;
					fetchData = readWord(fetchAddr);
				end
			end
		end
	end

	function automatic word_t rType(input logic [5:0] fn, input regAddr_t rd,
		input regAddr_t rs, input regAddr_t rt);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iType(input logic [5:0] op, input regAddr_t rt,
		input regAddr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(input logic [25:0] index);
		return {opJ, index};
	endfunction

	// sequential reference interpreter over the current program
	task automatic buildExpected;
		word_t gold [32];
		word_t pc;
		word_t instr;
		word_t a;
		word_t b;
		word_t result;
		logic writes;
		regAddr_t dest;
		int steps;
		foreach (gold[i])
			gold[i] = '0;
		expReg.delete();
		expData.delete();
		pc = resetPc;
		steps = 0;
		while ((pc[31:2] < prog.size()) && (steps < 1000))
		begin
			instr = prog[pc[31:2]];
			a = gold[instr[25:21]];
			b = gold[instr[20:16]];
			writes = 1'b1;
			dest = instr[20:16];
			result = '0;
			pc = pc + instrBytes;
			case (instr[31:26])
				opRType:
				begin
					dest = instr[15:11];
					case (instr[5:0])
						fnAdd: result = a + b;
						fnSub: result = a - b;
						fnAnd: result = a & b;
						fnOr: result = a | b;
						fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				opAddi: result = a + {{16{instr[15]}}, instr[15:0]};
				opAndi: result = a & {16'h0000, instr[15:0]};
				opOri: result = a | {16'h0000, instr[15:0]};
				opLui: result = {instr[15:0], 16'h0000};
				opBeq, opBne:
				begin
					writes = 1'b0;
					if ((a == b) == (instr[31:26] == opBeq))
						pc = pc + {{14{instr[15]}}, instr[15:0], 2'b00};
				end
				opJ:
				begin
					writes = 1'b0;
					pc = {pc[31:28], instr[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			if (writes)
			begin
				expReg.push_back(dest);
				expData.push_back(result);
				if (dest != '0)
					gold[dest] = result;
			end
			steps++;
		end
	endtask

	// reset held for 4 edges while optionally watching the outputs stay idle
	task automatic applyReset(input logic watch);
		@(posedge rst);
		#1;
		reset = 1'b1;
		repeat (4)
		begin
			@(posedge rst);
			#1;
			if (watch)
			begin
				checkFlag(fetchReq, 1'b0, "fetchReq during reset");
				checkFlag(wbValid, 1'b0, "wbValid during reset");
			end
		end
		reset = 1'b0;
	endtask

	task automatic startProgram(input logic watch);
		totalLen += prog.size();
		cycleLimit = totalLen * 12 + 200;
		buildExpected();
		applyReset(watch);
	endtask

	task automatic collectCommits;
		int seen;
		seen = 0;
		while (seen < expReg.size())
		begin
			@(negedge rst);
			if (wbValid)
			begin
				checkReg(wbReg, expReg[seen], $sformatf("commit %0d register", seen));
				checkWord(wbData, expData[seen], $sformatf("commit %0d data", seen));
				seen++;
			end
		end
		// the rest of memory holds no-ops so nothing more may commit
		repeat (12)
		begin
			@(negedge rst);
			if (wbValid)
				abortRun("An instruction committed after the last expected result");
		end
	endtask

	task automatic testReset;
		prog.delete();
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd5));
		prog.push_back(iType(opOri, 5'd2, 5'd1, 16'h00f0));
		startProgram(1'b1);
		@(posedge rst);
		#1;
		checkFlag(fetchReq, 1'b1, "first fetchReq after reset");
		checkWord(fetchAddr, 32'h0000_0000, "first fetch address");
		collectCommits();
	endtask

	task automatic testAluOps;
		prog.delete();
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'hfffd));
		prog.push_back(iType(opOri, 5'd2, 5'd0, 16'h8001));
		prog.push_back(iType(opLui, 5'd4, 5'd0, 16'h1234));
		prog.push_back(iType(opAddi, 5'd5, 5'd0, 16'h7fff));
		prog.push_back(iType(opAndi, 5'd6, 5'd1, 16'h8f0f));
		prog.push_back(rType(fnAdd, 5'd7, 5'd1, 5'd5));
		prog.push_back(32'h0000_0000);
		prog.push_back(rType(fnSub, 5'd8, 5'd5, 5'd1));
		prog.push_back(rType(fnAnd, 5'd9, 5'd1, 5'd2));
		prog.push_back(rType(6'b100111, 5'd14, 5'd1, 5'd2));
		prog.push_back(rType(fnOr, 5'd10, 5'd4, 5'd2));
		prog.push_back(rType(fnSlt, 5'd11, 5'd1, 5'd5));
		prog.push_back(rType(fnSlt, 5'd12, 5'd5, 5'd1));
		prog.push_back(iType(opAddi, 5'd13, 5'd0, 16'h8000));
		startProgram(1'b0);
		collectCommits();
	endtask

	task automatic testForwarding;
		prog.delete();
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd10));
		prog.push_back(iType(opAddi, 5'd2, 5'd1, 16'd7));
		prog.push_back(rType(fnAdd, 5'd3, 5'd1, 5'd2));
		prog.push_back(rType(fnSub, 5'd4, 5'd3, 5'd1));
		prog.push_back(rType(fnOr, 5'd5, 5'd4, 5'd4));
		prog.push_back(rType(fnSlt, 5'd6, 5'd5, 5'd3));
		prog.push_back(rType(fnAnd, 5'd7, 5'd6, 5'd5));
		prog.push_back(iType(opLui, 5'd8, 5'd0, 16'habcd));
		prog.push_back(iType(opOri, 5'd8, 5'd8, 16'h1234));
		prog.push_back(rType(fnAdd, 5'd9, 5'd8, 5'd8));
		startProgram(1'b0);
		collectCommits();
	endtask

	task automatic testBranches;
		prog.delete();
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd4));
		prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'd4));
		prog.push_back(iType(opBeq, 5'd2, 5'd1, 16'd2));
		prog.push_back(iType(opAddi, 5'd3, 5'd0, 16'd111));
		prog.push_back(iType(opAddi, 5'd3, 5'd0, 16'd222));
		prog.push_back(iType(opBne, 5'd2, 5'd1, 16'd1));
		prog.push_back(iType(opAddi, 5'd4, 5'd0, 16'd1));
		// branch right behind its producer
		prog.push_back(iType(opAddi, 5'd5, 5'd1, 16'hfffc));
		prog.push_back(iType(opBeq, 5'd0, 5'd5, 16'd1));
		prog.push_back(iType(opAddi, 5'd6, 5'd0, 16'd99));
		prog.push_back(iType(opAddi, 5'd7, 5'd0, 16'd3));
		prog.push_back(iType(opBne, 5'd1, 5'd7, 16'd2));
		prog.push_back(iType(opAddi, 5'd8, 5'd0, 16'd5));
		prog.push_back(iType(opAddi, 5'd8, 5'd0, 16'd6));
		prog.push_back(iType(opBeq, 5'd1, 5'd7, 16'd1));
		prog.push_back(rType(fnAdd, 5'd9, 5'd7, 5'd1));
		// count down loop with a backward branch
		prog.push_back(iType(opAddi, 5'd10, 5'd0, 16'd3));
		prog.push_back(iType(opAddi, 5'd10, 5'd10, 16'hffff));
		prog.push_back(iType(opBne, 5'd0, 5'd10, 16'hfffe));
		prog.push_back(rType(fnOr, 5'd11, 5'd10, 5'd7));
		startProgram(1'b0);
		collectCommits();
	endtask

	task automatic testJumps;
		prog.delete();
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd1));
		prog.push_back(jType(26'd3));
		prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd50));
		prog.push_back(iType(opAddi, 5'd2, 5'd1, 16'd2));
		prog.push_back(jType(26'd7));
		prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'd0));
		prog.push_back(iType(opAddi, 5'd3, 5'd0, 16'd0));
		prog.push_back(rType(fnAdd, 5'd3, 5'd2, 5'd1));
		prog.push_back(iType(opBeq, 5'd0, 5'd0, 16'd1));
		prog.push_back(iType(opAddi, 5'd3, 5'd0, 16'd77));
		prog.push_back(rType(fnSub, 5'd4, 5'd3, 5'd2));
		prog.push_back(jType(26'd13));
		prog.push_back(rType(fnOr, 5'd4, 5'd0, 5'd0));
		prog.push_back(rType(fnSlt, 5'd5, 5'd4, 5'd3));
		startProgram(1'b0);
		collectCommits();
	endtask

	initial
	begin
		rst = 1'b0;
		reset = 1'b1;
		fetchReady = 1'b0;
		fetchData = '0;
		testReset();
		testAluOps();
		testForwarding();
		testBranches();
		testJumps();
		if ((errorCount == 0) && (DUT.props.failCount == 0))
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/mipsPipe.sv
tests/mipsPipe_properties.sv
tests/mipsPipe_tb.sv
